//--- Bender.yml
package:
  name: stash_eviction

sources:
  - files:
      - hw/oramPkg.sv
      - hw/stashPkg.sv
      - hw/stashRam.sv
      - hw/bucketPlacer.sv
      - hw/stashStore.sv
      - hw/evictionReader.sv
      - hw/stashEviction.sv
  - target: test
    files:
      - verif/stashEvictionTb.sv

//--- hw/bucketPlacer.sv
/* Per-block placement decision during the stash scan.
   Picks the deepest common bucket with room, bumps its count, records the entry. */
`timescale 1ns/1ps
`default_nettype none

module bucketPlacer
	import oramPkg::*, stashPkg::*;
(
	input wire logic Clock,
	input wire logic rstN,
	input wire logic ClearCounts,
	input wire leafT CurrentLeaf,
	input wire logic ScanValid,
	input wire stashAddrT ScanAddr,
	input wire stashEntryT ScanEntry,
	output logic Accepted,
	output logic TableWrite,
	output scanAddrT TableAddr,
	output stashAddrT TableData,
	output bucketCountT [NumLevels-1:0] Counts
);

	// Bit 0 stands for the root, bit j for level j
	logic [NumLevels-1:0] leafDiff;
	logic [NumLevels-1:0] commonMask;
	logic [NumLevels-1:0] fullMask;
	logic [NumLevels-1:0] spaceMask;
	logic [NumLevels-1:0] deepestOneHot;
	levelT deepestLevel;
	bucketCountT deepestCount;

	// ----------------------------------------------------------
	// Common path
	// ----------------------------------------------------------

	// Root never differs, hence the zero shifted in
	assign leafDiff = {ScanEntry.leaf ^ CurrentLeaf, 1'b0};

	// Levels below the first differing bit are shared
	// No difference at all wraps to all ones
	assign commonMask = (leafDiff & -leafDiff) - 1'b1;

	always_comb begin
		for (int j = 0; j < NumLevels; j++) begin
			fullMask[j] = (Counts[j] == bucketCountT'(ORAMZ));
		end
	end

	assign spaceMask = commonMask & ~fullMask;

	// ----------------------------------------------------------
	// Deepest level with space
	// ----------------------------------------------------------

	// Scan from the leaf upwards, first hit wins
	always_comb begin
		deepestOneHot = '0;
		for (int j = NumLevels - 1; j >= 0; j--) begin
			if (spaceMask[j] && (deepestOneHot == '0)) begin
				deepestOneHot[j] = 1'b1;
			end
		end
	end

	// One-hot to binary
	always_comb begin
		deepestLevel = '0;
		for (int j = 0; j < NumLevels; j++) begin
			if (deepestOneHot[j]) begin
				deepestLevel = deepestLevel | levelT'(j);
			end
		end
	end

	assign deepestCount = Counts[deepestLevel];

	// ----------------------------------------------------------
	// Decision and scan table write
	// ----------------------------------------------------------

	// Empty mask means every common bucket is full
	assign Accepted = ScanValid & (|deepestOneHot);

	assign TableWrite = Accepted;
	// Level-major layout, ORAMZ entries per level
	assign TableAddr = scanAddrT'(int'(deepestLevel) * ORAMZ + int'(deepestCount));
	assign TableData = ScanAddr;

	// Occupancy per bucket for this access
	always_ff @(posedge Clock) begin
		if (!rstN || ClearCounts) begin
			Counts <= '0;
		end else if (Accepted) begin
			Counts[deepestLevel] <= deepestCount + 1'b1;
		end
	end

	for (genvar j = 0; j < NumLevels; j++) begin : gCountCheck
		// Full buckets must drop out of the mask before overflow
		assert property (@(posedge Clock) disable iff (!rstN)
			Counts[j] <= bucketCountT'(ORAMZ));
	end

endmodule

`default_nettype wire

//--- hw/evictionReader.sv
/* Turns the filled scan table into the ordered write-back plan.
   Level 0 slot 0 first, one slot per cycle, after a two-cycle fill. */
`timescale 1ns/1ps
`default_nettype none

module evictionReader
	import oramPkg::*, stashPkg::*;
(
	input wire logic Clock,
	input wire logic rstN,
	input wire logic Start,
	input wire bucketCountT [NumLevels-1:0] Counts,
	output scanAddrT TableRdAddr,
	input wire stashAddrT TableRdData,
	output stashAddrT StashRdAddr,
	input wire stashEntryT StashRdEntry,
	output logic PlanValid,
	output evictSlotT PlanSlot,
	output logic Busy,
	output logic AccessDone
);

	// Stage 0 issues table reads
	logic issuing;
	levelT levelCnt;
	slotT slotCnt;
	// Stage 1 has table data, issues the stash read
	logic s1Valid;
	levelT s1Level;
	slotT s1Slot;
	// Stage 2 has stash data
	logic s2Valid;
	levelT s2Level;
	slotT s2Slot;
	logic s2Real;
	logic lastSlot;

	// ----------------------------------------------------------
	// Slot walk
	// ----------------------------------------------------------

	assign TableRdAddr = scanAddrT'(int'(levelCnt) * ORAMZ + int'(slotCnt));
	assign StashRdAddr = TableRdData;
	assign lastSlot = (s2Level == levelT'(NumLevels - 1)) && (s2Slot == slotT'(ORAMZ - 1));

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			issuing <= 1'b0;
			levelCnt <= '0;
			slotCnt <= '0;
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			Busy <= 1'b0;
			AccessDone <= 1'b0;
		end else begin
			s1Valid <= issuing;
			s2Valid <= s1Valid;
			AccessDone <= s2Valid && lastSlot;
			if (Start) begin
				issuing <= 1'b1;
				Busy <= 1'b1;
			end else if (AccessDone) begin
				Busy <= 1'b0;
			end
			if (issuing) begin
				if (slotCnt == slotT'(ORAMZ - 1)) begin
					slotCnt <= '0;
					// Counters wrap back to zero for the next access
					if (levelCnt == levelT'(NumLevels - 1)) begin
						levelCnt <= '0;
						issuing <= 1'b0;
					end else begin
						levelCnt <= levelCnt + 1'b1;
					end
				end else begin
					slotCnt <= slotCnt + 1'b1;
				end
			end
		end
	end

	// Position travels with the reads
	always_ff @(posedge Clock) begin
		s1Level <= levelCnt;
		s1Slot <= slotCnt;
		s2Level <= s1Level;
		s2Slot <= s1Slot;
		// Slots past the count were never written this access
		s2Real <= bucketCountT'(s1Slot) < Counts[s1Level];
	end

	// ----------------------------------------------------------
	// Plan output
	// ----------------------------------------------------------

	always_comb begin
		PlanSlot = '0;
		if (s2Valid) begin
			PlanSlot.level = s2Level;
			PlanSlot.slot = s2Slot;
			if (s2Real) begin
				PlanSlot.isReal = 1'b1;
				PlanSlot.pAddr = StashRdEntry.pAddr;
				PlanSlot.leaf = StashRdEntry.leaf;
			end
		end
	end

	assign PlanValid = s2Valid;

endmodule

`default_nettype wire

//--- hw/oramPkg.sv
/* Tree geometry shared by the eviction planner.
   Import where levels, leaves, bucket counts or scan table addresses appear. */
`default_nettype none

package oramPkg;

	// ----------------------------------------------------------
	// Geometry
	// ----------------------------------------------------------

	// Leaf label bits, also the deepest level number
	localparam int ORAML = 4;
	// Slots per bucket
	localparam int ORAMZ = 4;
	// Root at level 0, leaves at level ORAML
	localparam int NumLevels = ORAML + 1;
	// One scan table entry per slot on the path
	localparam int ScanTableDepth = NumLevels * ORAMZ;

	// ----------------------------------------------------------
	// Types
	// ----------------------------------------------------------

	typedef logic [2:0] levelT;
	typedef logic [$clog2(ORAMZ)-1:0] slotT;
	typedef logic [ORAML-1:0] leafT;
	// Must hold 0 up to ORAMZ inclusive
	typedef logic [2:0] bucketCountT;
	typedef logic [4:0] scanAddrT;

endpackage

`default_nettype wire

//--- hw/stashEviction.sv
/* Eviction planner top: stash, placer, scan table and plan reader.
   Inserts and access starts are dropped while busy; inserts also while full. */
`timescale 1ns/1ps
`default_nettype none

module stashEviction
	import oramPkg::*, stashPkg::*;
(
	input wire logic Clock,
	input wire logic rstN,
	input wire logic Insert,
	input wire insertT InsertData,
	input wire logic StartAccess,
	input wire leafT CurrentLeaf,
	output logic StashFull,
	output logic Busy,
	output logic PlanValid,
	output evictSlotT PlanSlot,
	output logic AccessDone
);

	logic insertOk;
	logic startOk;
	logic scanPhase;
	logic readerBusy;
	logic scanValid;
	stashAddrT scanAddr;
	stashEntryT scanEntry;
	logic scanDone;
	logic accepted;
	leafT pathLeaf;
	logic tableWrite;
	scanAddrT tableWrAddr;
	stashAddrT tableWrData;
	scanAddrT tableRdAddr;
	stashAddrT tableRdData;
	stashAddrT planRdAddr;
	stashEntryT planRdEntry;
	bucketCountT [NumLevels-1:0] counts;

	// ----------------------------------------------------------
	// Input gating and busy
	// ----------------------------------------------------------

	assign insertOk = Insert & ~Busy & ~StashFull;
	assign startOk = StartAccess & ~Busy;

	// Scan half of the access, reader covers the rest
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			scanPhase <= 1'b0;
		end else if (startOk) begin
			scanPhase <= 1'b1;
		end else if (scanDone) begin
			scanPhase <= 1'b0;
		end
	end

	assign Busy = scanPhase | readerBusy;

	// ----------------------------------------------------------
	// Blocks
	// ----------------------------------------------------------

	stashStore i_stashStore (
		.Clock(Clock),
		.rstN(rstN),
		.Insert(insertOk),
		.InsertData(InsertData),
		.StartAccess(startOk),
		.CurrentLeafIn(CurrentLeaf),
		.StashFull(StashFull),
		.ScanValid(scanValid),
		.ScanAddr(scanAddr),
		.ScanEntry(scanEntry),
		.ScanDone(scanDone),
		.Accepted(accepted),
		.PlanRdAddr(planRdAddr),
		.PlanRdEntry(planRdEntry),
		.CurrentLeaf(pathLeaf)
	);

	bucketPlacer i_bucketPlacer (
		.Clock(Clock),
		.rstN(rstN),
		.ClearCounts(startOk),
		.CurrentLeaf(pathLeaf),
		.ScanValid(scanValid),
		.ScanAddr(scanAddr),
		.ScanEntry(scanEntry),
		.Accepted(accepted),
		.TableWrite(tableWrite),
		.TableAddr(tableWrAddr),
		.TableData(tableWrData),
		.Counts(counts)
	);

	// Stash address per path slot
	stashRam #(
		.payloadT(stashAddrT),
		.Depth(ScanTableDepth)
	) i_scanTable (
		.Clock(Clock),
		.rstN(rstN),
		.Write(tableWrite),
		.WrAddr(tableWrAddr),
		.WrData(tableWrData),
		.RdAddr(tableRdAddr),
		.RdData(tableRdData)
	);

	evictionReader i_evictionReader (
		.Clock(Clock),
		.rstN(rstN),
		.Start(scanDone),
		.Counts(counts),
		.TableRdAddr(tableRdAddr),
		.TableRdData(tableRdData),
		.StashRdAddr(planRdAddr),
		.StashRdEntry(planRdEntry),
		.PlanValid(PlanValid),
		.PlanSlot(PlanSlot),
		.Busy(readerBusy),
		.AccessDone(AccessDone)
	);

endmodule

`default_nettype wire

//--- hw/stashPkg.sv
/* Stash sizes and the structs that move stash blocks around.
   Pulls in the tree types, so import it alongside oramPkg. */
`default_nettype none

package stashPkg;

	import oramPkg::*;

	// ----------------------------------------------------------
	// Sizes
	// ----------------------------------------------------------

	localparam int StashDepth = 16;

	typedef logic [3:0] stashAddrT;
	typedef logic [15:0] pAddrT;

	// ----------------------------------------------------------
	// Structs
	// ----------------------------------------------------------

	// Payload kept in the stash RAM
	typedef struct packed {
		pAddrT pAddr;
		leafT leaf;
	} stashEntryT;

	// Block handed in on the insert port
	typedef struct packed {
		pAddrT pAddr;
		leafT leaf;
	} insertT;

	// One slot of the write-back plan
	// Dummy slots carry zero pAddr and leaf
	typedef struct packed {
		levelT level;
		slotT slot;
		logic isReal;
		pAddrT pAddr;
		leafT leaf;
	} evictSlotT;

endpackage

`default_nettype wire

//--- hw/stashRam.sv
/* Register-array RAM with one write port and a registered read port.
   The payload type is a parameter, so the stash and the scan table share it. */
`timescale 1ns/1ps
`default_nettype none

module stashRam #(
	parameter type payloadT = logic [7:0],
	parameter int Depth = 16
) (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic Write,
	input wire logic [$clog2(Depth)-1:0] WrAddr,
	input wire payloadT WrData,
	input wire logic [$clog2(Depth)-1:0] RdAddr,
	output payloadT RdData
);

	payloadT mem [Depth];

	// Write and read both land on the clock edge
	always_ff @(posedge Clock) begin
		if (Write) begin
			mem[WrAddr] <= WrData;
		end
		// Old data on a same-address collision
		RdData <= mem[RdAddr];
	end

	// Depth need not be a power of two, scan table is 20 deep
	assert property (@(posedge Clock) disable iff (!rstN)
		Write |-> (int'(WrAddr) < Depth));

endmodule

`default_nettype wire

//--- hw/stashStore.sv
/* Stash storage with valid bits and lowest-free allocation.
   On start it replays every entry to the placer and drops those it accepts. */
`timescale 1ns/1ps
`default_nettype none

module stashStore
	import oramPkg::*, stashPkg::*;
(
	input wire logic Clock,
	input wire logic rstN,
	input wire logic Insert,
	input wire insertT InsertData,
	input wire logic StartAccess,
	input wire leafT CurrentLeafIn,
	output logic StashFull,
	output logic ScanValid,
	output stashAddrT ScanAddr,
	output stashEntryT ScanEntry,
	output logic ScanDone,
	input wire logic Accepted,
	input wire stashAddrT PlanRdAddr,
	output stashEntryT PlanRdEntry,
	output leafT CurrentLeaf
);

	logic [StashDepth-1:0] validBits;
	stashAddrT freeAddr;
	stashAddrT ramRdAddr;
	stashEntryT ramWrData;
	stashEntryT ramRdData;
	logic scanning;
	stashAddrT scanCnt;
	// Valid bit of the entry the RAM is presenting
	logic scanValidQ;

	// ----------------------------------------------------------
	// Allocation
	// ----------------------------------------------------------

	// Lowest free entry, walk down so the smallest index sticks
	always_comb begin
		freeAddr = '0;
		for (int i = StashDepth - 1; i >= 0; i--) begin
			if (!validBits[i]) begin
				freeAddr = stashAddrT'(i);
			end
		end
	end

	assign StashFull = &validBits;
	assign ramWrData = '{pAddr: InsertData.pAddr, leaf: InsertData.leaf};

	// ----------------------------------------------------------
	// Scan sequencing
	// ----------------------------------------------------------

	// Entry 0 is fetched in the start cycle itself
	// Plan reader owns the port outside the scan
	always_comb begin
		if (StartAccess) begin
			ramRdAddr = '0;
		end else if (scanning) begin
			ramRdAddr = scanCnt + 1'b1;
		end else begin
			ramRdAddr = PlanRdAddr;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			validBits <= '0;
			scanning <= 1'b0;
			scanCnt <= '0;
			scanValidQ <= 1'b0;
		end else begin
			// Same latency as the RAM read
			scanValidQ <= validBits[ramRdAddr];
			if (Insert) begin
				validBits[freeAddr] <= 1'b1;
			end
			// Placed blocks leave the stash
			if (Accepted) begin
				validBits[ScanAddr] <= 1'b0;
			end
			if (StartAccess) begin
				scanning <= 1'b1;
				scanCnt <= '0;
			end else if (scanning) begin
				scanCnt <= scanCnt + 1'b1;
				if (ScanDone) begin
					scanning <= 1'b0;
				end
			end
		end
	end

	// Leaf of the path being evicted, held for the whole scan
	always_ff @(posedge Clock) begin
		if (StartAccess) begin
			CurrentLeaf <= CurrentLeafIn;
		end
	end

	assign ScanValid = scanning & scanValidQ;
	assign ScanAddr = scanCnt;
	assign ScanEntry = ramRdData;
	assign ScanDone = scanning && (scanCnt == stashAddrT'(StashDepth - 1));
	assign PlanRdEntry = ramRdData;

	stashRam #(
		.payloadT(stashEntryT),
		.Depth(StashDepth)
	) i_stashRam (
		.Clock(Clock),
		.rstN(rstN),
		.Write(Insert),
		.WrAddr(freeAddr),
		.WrData(ramWrData),
		.RdAddr(ramRdAddr),
		.RdData(ramRdData)
	);

	// Top level gates inserts on full and busy
	assert property (@(posedge Clock) disable iff (!rstN)
		Insert |-> (!StashFull && !scanning));

endmodule

`default_nettype wire

//--- list.f
hw/oramPkg.sv
hw/stashPkg.sv
hw/stashRam.sv
hw/bucketPlacer.sv
hw/stashStore.sv
hw/evictionReader.sv
hw/stashEviction.sv
verif/stashEvictionTb.sv

//--- verif/stashEvictionTb.sv
/* Testbench for the stash eviction planner. Drives inserts and accesses,
   predicts each write-back plan with a mirror stash and checks every slot. */
`timescale 1ns/1ps
`default_nettype none

module stashEvictionTb
	import oramPkg::*, stashPkg::*;
();

	// StartAccess to AccessDone in cycles
	localparam int AccessCycles = StashDepth + 2 + ScanTableDepth + 1;
	localparam int RandAccesses = 5;
	localparam int NumAccesses = RandAccesses + 3;
	localparam int MaxInserts = 10 + RandAccesses * 8 + StashDepth + 1;
	localparam int WatchdogCycles = 3 + NumAccesses * (AccessCycles + 2) + MaxInserts + 100;

	logic Clock;
	logic rstN;
	logic Insert;
	insertT InsertData;
	logic StartAccess;
	leafT CurrentLeaf;
	logic StashFull;
	logic Busy;
	logic PlanValid;
	evictSlotT PlanSlot;
	logic AccessDone;

	// Mirror stash
	logic mValid [StashDepth];
	pAddrT mAddr [StashDepth];
	leafT mLeaf [StashDepth];
	// Expected plan slots in emission order
	evictSlotT expQ [$];
	logic [31:0] lcgState = 32'h26e0;
	string testName;
	int testChecks;
	int testErrors;
	int totalChecks;
	int totalErrors;

	stashEviction i_stashEviction (
		.Clock(Clock),
		.rstN(rstN),
		.Insert(Insert),
		.InsertData(InsertData),
		.StartAccess(StartAccess),
		.CurrentLeaf(CurrentLeaf),
		.StashFull(StashFull),
		.Busy(Busy),
		.PlanValid(PlanValid),
		.PlanSlot(PlanSlot),
		.AccessDone(AccessDone)
	);

	initial begin
		Clock = 1'b0;
		forever begin
			#10 Clock = ~Clock;
		end
	end

	// ----------------------------------------------------------
	// Helpers and reference model
	// ----------------------------------------------------------

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic modelFull();
		logic full;
		full = 1'b1;
		for (int i = 0; i < StashDepth; i++) begin
			full = full & mValid[i];
		end
		return full;
	endfunction

	// Place mirror blocks in address order and queue the 20 expected slots
	function automatic void planAccess(input leafT pathLeaf);
		int cnt [NumLevels];
		pAddrT tblAddr [NumLevels][ORAMZ];
		leafT tblLeaf [NumLevels][ORAMZ];
		int lv;
		leafT mask;
		evictSlotT e;
		for (int j = 0; j < NumLevels; j++) begin
			cnt[j] = 0;
		end
		for (int i = 0; i < StashDepth; i++) begin
			lv = -1;
			// Deepest level first
			// Level j needs the low j leaf bits to match
			for (int j = NumLevels - 1; j >= 0; j--) begin
				mask = leafT'((1 << j) - 1);
				if (lv < 0 && cnt[j] < ORAMZ
					&& ((mLeaf[i] & mask) == (pathLeaf & mask))) begin
					lv = j;
				end
			end
			if (mValid[i] && lv >= 0) begin
				tblAddr[lv][cnt[lv]] = mAddr[i];
				tblLeaf[lv][cnt[lv]] = mLeaf[i];
				cnt[lv]++;
				mValid[i] = 1'b0;
			end
		end
		// Root slot 0 first and leaf slot 3 last
		for (int j = 0; j < NumLevels; j++) begin
			for (int s = 0; s < ORAMZ; s++) begin
				e = '0;
				e.level = levelT'(j);
				e.slot = slotT'(s);
				if (s < cnt[j]) begin
					e.isReal = 1'b1;
					e.pAddr = tblAddr[j][s];
					e.leaf = tblLeaf[j][s];
				end
				expQ.push_back(e);
			end
		end
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expVal,
		input logic [31:0] actVal);
		testChecks++;
		assert (actVal === expVal) else begin
			$display("Fail %s %s: expected %h, actual %h", testName, what, expVal, actVal);
			testErrors++;
		end
	endtask

	task automatic finishTest();
		$display("Test %s done: %0d checks, %0d errors", testName, testChecks, testErrors);
		totalChecks += testChecks;
		totalErrors += testErrors;
		testChecks = 0;
		testErrors = 0;
	endtask

	// Called and returns on a falling edge
	task automatic insertBlock(input pAddrT addr, input leafT leaf);
		int freeSlot;
		freeSlot = -1;
		for (int i = 0; i < StashDepth; i++) begin
			if (!mValid[i] && freeSlot < 0) begin
				freeSlot = i;
			end
		end
		Insert = 1'b1;
		InsertData = '{pAddr: addr, leaf: leaf};
		@(negedge Clock);
		Insert = 1'b0;
		// Full stash drops the block
		if (freeSlot >= 0) begin
			mValid[freeSlot] = 1'b1;
			mAddr[freeSlot] = addr;
			mLeaf[freeSlot] = leaf;
		end
		checkValue("StashFull", modelFull(), StashFull);
	endtask

	task automatic runAccess(input leafT pathLeaf);
		int cycles;
		planAccess(pathLeaf);
		StartAccess = 1'b1;
		CurrentLeaf = pathLeaf;
		cycles = 0;
		do begin
			@(negedge Clock);
			StartAccess = 1'b0;
			cycles++;
			// Busy holds through the AccessDone cycle
			checkValue("Busy during access", 1, Busy);
		end while (!AccessDone && cycles < 2 * AccessCycles);
		if (AccessDone) begin
			checkValue("AccessDone latency", AccessCycles, cycles);
		end else begin
			testErrors++;
			$display("Test %s: AccessDone never arrived", testName);
		end
		checkValue("slots left over", 0, expQ.size());
		expQ.delete();
		@(negedge Clock);
		checkValue("Busy after access", 0, Busy);
	endtask

	// ----------------------------------------------------------
	// Plan slot comparison
	// ----------------------------------------------------------

	initial begin : comparePlan
		evictSlotT expSlot;
		forever begin
			@(negedge Clock);
			if (rstN && PlanValid) begin
				if (expQ.size() == 0) begin
					testErrors++;
					$display("Test %s: plan slot arrived with none expected", testName);
				end else begin
					expSlot = expQ.pop_front();
					checkValue($sformatf("slot L%0d S%0d", expSlot.level, expSlot.slot),
						expSlot, PlanSlot);
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WatchdogCycles) @(posedge Clock);
		$display("Watchdog: run still going after %0d cycles", WatchdogCycles);
		$display("Checks failed");
		$finish;
	end

	// ----------------------------------------------------------
	// Tests
	// ----------------------------------------------------------

	initial begin : mainSeq
		logic [31:0] r;
		int n;
		rstN = 1'b0;
		Insert = 1'b0;
		InsertData = '0;
		StartAccess = 1'b0;
		CurrentLeaf = '0;
		testChecks = 0;
		testErrors = 0;
		totalChecks = 0;
		totalErrors = 0;
		for (int i = 0; i < StashDepth; i++) begin
			mValid[i] = 1'b0;
		end
		repeat (3) @(negedge Clock);
		rstN = 1'b1;

		testName = "resetEmpty";
		@(negedge Clock);
		checkValue("StashFull", 0, StashFull);
		checkValue("Busy", 0, Busy);
		checkValue("PlanValid", 0, PlanValid);
		runAccess(4'h3);
		finishTest();

		// Ten blocks on the path leaf
		// Four land at the leaf, four at level 3 and two at level 2
		testName = "sameLeaf";
		for (int i = 0; i < 10; i++) begin
			insertBlock(pAddrT'(16'h0100 + i), 4'hA);
		end
		runAccess(4'hA);
		finishTest();

		testName = "randomLeaves";
		for (int a = 0; a < RandAccesses; a++) begin
			r = nextRand();
			n = int'(r[26:24]) + 1;
			for (int i = 0; i < n; i++) begin
				r = nextRand();
				insertBlock(r[31:16], r[23:20]);
			end
			r = nextRand();
			runAccess(r[27:24]);
		end
		finishTest();

		// Fill whatever is left and then add one that must be dropped
		testName = "fullStash";
		for (int i = 0; i < StashDepth && !modelFull(); i++) begin
			r = nextRand();
			insertBlock(r[31:16], r[23:20]);
		end
		checkValue("StashFull when full", 1, StashFull);
		insertBlock(16'hDEAD, 4'h5);
		r = nextRand();
		runAccess(r[27:24]);
		finishTest();

		$display("Totals: %0d checks, %0d errors", totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
